// ==== common/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

    typedef logic [7:0] byte_t;
    typedef logic [15:0] addr_t;

    // Control word bit positions
    // Stack bus and data bus sources
    localparam int SB_FROM_ACC       = 0;
    localparam int SB_FROM_X         = 1;
    localparam int SB_FROM_Y         = 2;
    localparam int SB_FROM_SP        = 3;
    localparam int SB_FROM_ALU       = 4;
    localparam int DB_FROM_ACC       = 5;
    localparam int DB_FROM_SB        = 6;
    localparam int DB_HIGH           = 7;
    // ALU input selects
    localparam int A_FROM_SB         = 8;
    localparam int A_LOW             = 9;
    localparam int B_FROM_DB         = 10;
    localparam int CARRY_IN_HIGH     = 11;
    localparam int CARRY_IN_FROM_PSR = 12;
    // ALU operation
    localparam int ALU_ADD           = 13;
    localparam int ALU_SHR           = 14;
    localparam int LOAD_ALU          = 15;
    // Register loads from the stack bus
    localparam int LOAD_ACC          = 16;
    localparam int LOAD_X            = 17;
    localparam int LOAD_Y            = 18;
    localparam int LOAD_SP           = 19;
    // Status flag updates
    localparam int CARRY_FROM_ALU    = 20;
    localparam int PSR_DATA          = 21;
    localparam int LOAD_C            = 22;
    localparam int LOAD_D            = 23;
    localparam int LOAD_I            = 24;
    localparam int LOAD_V            = 25;
    // Program counter and address bus
    localparam int PC_INC            = 26;
    localparam int LOAD_AB           = 27;

    localparam int NUM_CTRL = 28;

    typedef logic [NUM_CTRL-1:0] ctrl_word_t;

    typedef enum logic [1:0] {
        SEQ_IDLE = 2'd0,
        SEQ_T0   = 2'd1,
        SEQ_T1   = 2'd2
    } seq_state_e;

    // Single-byte opcodes, standard 6502 encodings
    localparam byte_t OP_ASL_A = 8'h0A;
    localparam byte_t OP_ROL_A = 8'h2A;
    localparam byte_t OP_LSR_A = 8'h4A;
    localparam byte_t OP_ROR_A = 8'h6A;
    localparam byte_t OP_DEX   = 8'hCA;
    localparam byte_t OP_DEY   = 8'h88;
    localparam byte_t OP_INX   = 8'hE8;
    localparam byte_t OP_INY   = 8'hC8;
    localparam byte_t OP_NOP   = 8'hEA;
    localparam byte_t OP_TAX   = 8'hAA;
    localparam byte_t OP_TAY   = 8'hA8;
    localparam byte_t OP_TSX   = 8'hBA;
    localparam byte_t OP_TXA   = 8'h8A;
    localparam byte_t OP_TXS   = 8'h9A;
    localparam byte_t OP_TYA   = 8'h98;
    localparam byte_t OP_SEC   = 8'h38;
    localparam byte_t OP_SED   = 8'hF8;
    localparam byte_t OP_SEI   = 8'h78;
    localparam byte_t OP_CLC   = 8'h18;
    localparam byte_t OP_CLD   = 8'hD8;
    localparam byte_t OP_CLI   = 8'h58;
    localparam byte_t OP_CLV   = 8'hB8;

    // Status byte bit positions
    localparam int PSR_C = 0;
    localparam int PSR_I = 2;
    localparam int PSR_D = 3;
    localparam int PSR_V = 6;

    localparam addr_t RESET_PC = 16'h0400;
    localparam byte_t RESET_SP = 8'hFF;

endpackage

`default_nettype wire

// ==== datapath/address_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module address_unit import cpu_pkg::*; (
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire ctrl_word_t  ctrl,
    output addr_t            address
);

    addr_t pc;
    addr_t pc_next;

    assign pc_next = ctrl[PC_INC] ? pc + 16'd1 : pc;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc      <= RESET_PC;
            address <= RESET_PC;
        end else begin
            pc <= pc_next;
            // Address bus follows the PC after its increment
            if (ctrl[LOAD_AB]) begin
                address <= pc_next;
            end
        end
    end

    // Every load of the address bus lands one past the old address
    a_ab_tracks_pc: assert property (@(posedge clk) disable iff (reset)
        (ctrl[LOAD_AB] && ctrl[PC_INC]) |=> (address == $past(address) + 16'd1))
        else $error("address bus out of step with PC");

endmodule

`default_nettype wire

// ==== datapath/bus_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_alu import cpu_pkg::*; (
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire ctrl_word_t  ctrl,
    input  wire byte_t       alu_a,
    input  wire byte_t       alu_b,
    input  wire logic        alu_carry_in,
    output byte_t            alu_result,
    output logic             alu_carry_out
);

    logic [8:0] sum;
    byte_t      result_d;
    logic       carry_d;

    assign sum = {1'b0, alu_a} + {1'b0, alu_b} + {8'h00, alu_carry_in};

    always_comb begin
        if (ctrl[ALU_SHR]) begin
            // Carry enters at bit 7, bit 0 leaves as carry
            result_d = {alu_carry_in, alu_a[7:1]};
            carry_d  = alu_a[0];
        end else if (ctrl[ALU_ADD]) begin
            result_d = sum[7:0];
            carry_d  = sum[8];
        end else begin
            result_d = 8'h00;
            carry_d  = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            alu_result    <= 8'h00;
            alu_carry_out <= 1'b0;
        end else if (ctrl[LOAD_ALU]) begin
            alu_result    <= result_d;
            alu_carry_out <= carry_d;
        end
    end

    a_one_alu_op: assert property (@(posedge clk) disable iff (reset)
        !(ctrl[ALU_ADD] && ctrl[ALU_SHR]))
        else $error("ALU add and shift selected together");

endmodule

`default_nettype wire

// ==== datapath/register_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module register_file import cpu_pkg::*; (
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire ctrl_word_t  ctrl,
    input  wire byte_t       alu_result,
    input  wire logic        alu_carry_out,
    output byte_t            alu_a,
    output byte_t            alu_b,
    output logic             alu_carry_in,
    output byte_t            acc,
    output byte_t            x,
    output byte_t            y,
    output byte_t            sp,
    output byte_t            psr
);

    byte_t sb;
    byte_t db;
    logic  c_flag;
    logic  d_flag;
    logic  i_flag;
    logic  v_flag;

    // Stack bus is a wired OR of the enabled sources
    assign sb = ({8{ctrl[SB_FROM_ACC]}} & acc)
              | ({8{ctrl[SB_FROM_X]}}   & x)
              | ({8{ctrl[SB_FROM_Y]}}   & y)
              | ({8{ctrl[SB_FROM_SP]}}  & sp)
              | ({8{ctrl[SB_FROM_ALU]}} & alu_result);

    assign db = ctrl[DB_FROM_ACC] ? acc :
                ctrl[DB_FROM_SB]  ? sb  :
                ctrl[DB_HIGH]     ? 8'hFF : 8'h00;

    // A_LOW forces the A input to zero
    assign alu_a = (ctrl[A_FROM_SB] && !ctrl[A_LOW]) ? sb : 8'h00;
    assign alu_b = ctrl[B_FROM_DB] ? db : 8'h00;
    assign alu_carry_in = ctrl[CARRY_IN_HIGH] | (ctrl[CARRY_IN_FROM_PSR] & c_flag);

    always_ff @(posedge clk) begin
        if (reset) begin
            acc <= 8'h00;
            x   <= 8'h00;
            y   <= 8'h00;
            sp  <= RESET_SP;
        end else begin
            if (ctrl[LOAD_ACC]) acc <= sb;
            if (ctrl[LOAD_X])   x   <= sb;
            if (ctrl[LOAD_Y])   y   <= sb;
            if (ctrl[LOAD_SP])  sp  <= sb;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            c_flag <= 1'b0;
            d_flag <= 1'b0;
            i_flag <= 1'b0;
            v_flag <= 1'b0;
        end else begin
            // Shifts take C from the ALU, flag opcodes from PSR_DATA
            if (ctrl[CARRY_FROM_ALU]) begin
                c_flag <= alu_carry_out;
            end else if (ctrl[LOAD_C]) begin
                c_flag <= ctrl[PSR_DATA];
            end
            if (ctrl[LOAD_D]) d_flag <= ctrl[PSR_DATA];
            if (ctrl[LOAD_I]) i_flag <= ctrl[PSR_DATA];
            if (ctrl[LOAD_V]) v_flag <= ctrl[PSR_DATA];
        end
    end

    always_comb begin
        psr = 8'h00;
        psr[PSR_C] = c_flag;
        psr[PSR_I] = i_flag;
        psr[PSR_D] = d_flag;
        psr[PSR_V] = v_flag;
    end

endmodule

`default_nettype wire

// ==== decode/implied_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module implied_decoder import cpu_pkg::*; (
    input  wire byte_t       cur_opcode,
    input  wire seq_state_e  t_state,
    output ctrl_word_t       ctrl
);

    always_comb begin
        ctrl = '0;
        case (t_state)
            SEQ_T0: begin
                unique case (cur_opcode)
                    OP_ASL_A, OP_ROL_A: begin
                        // A + A, carry from C only for ROL
                        ctrl[SB_FROM_ACC] = 1'b1;
                        ctrl[DB_FROM_ACC] = 1'b1;
                        ctrl[A_FROM_SB] = 1'b1;
                        ctrl[B_FROM_DB] = 1'b1;
                        ctrl[CARRY_IN_FROM_PSR] = (cur_opcode == OP_ROL_A);
                        ctrl[ALU_ADD] = 1'b1;
                        ctrl[LOAD_ALU] = 1'b1;
                    end
                    OP_LSR_A, OP_ROR_A: begin
                        ctrl[SB_FROM_ACC] = 1'b1;
                        ctrl[A_FROM_SB] = 1'b1;
                        ctrl[CARRY_IN_FROM_PSR] = (cur_opcode == OP_ROR_A);
                        ctrl[ALU_SHR] = 1'b1;
                        ctrl[LOAD_ALU] = 1'b1;
                    end
                    OP_DEX, OP_DEY: begin
                        // Index plus FF
                        ctrl[SB_FROM_X] = (cur_opcode == OP_DEX);
                        ctrl[SB_FROM_Y] = (cur_opcode == OP_DEY);
                        ctrl[DB_HIGH] = 1'b1;
                        ctrl[A_FROM_SB] = 1'b1;
                        ctrl[B_FROM_DB] = 1'b1;
                        ctrl[ALU_ADD] = 1'b1;
                        ctrl[LOAD_ALU] = 1'b1;
                    end
                    OP_INX, OP_INY: begin
                        // Zero plus index plus carry-in
                        ctrl[SB_FROM_X] = (cur_opcode == OP_INX);
                        ctrl[SB_FROM_Y] = (cur_opcode == OP_INY);
                        ctrl[DB_FROM_SB] = 1'b1;
                        ctrl[A_LOW] = 1'b1;
                        ctrl[B_FROM_DB] = 1'b1;
                        ctrl[CARRY_IN_HIGH] = 1'b1;
                        ctrl[ALU_ADD] = 1'b1;
                        ctrl[LOAD_ALU] = 1'b1;
                    end
                    OP_TAX: begin
                        ctrl[SB_FROM_ACC] = 1'b1;
                        ctrl[LOAD_X] = 1'b1;
                    end
                    OP_TAY: begin
                        ctrl[SB_FROM_ACC] = 1'b1;
                        ctrl[LOAD_Y] = 1'b1;
                    end
                    OP_TSX: begin
                        ctrl[SB_FROM_SP] = 1'b1;
                        ctrl[LOAD_X] = 1'b1;
                    end
                    OP_TXA: begin
                        ctrl[SB_FROM_X] = 1'b1;
                        ctrl[LOAD_ACC] = 1'b1;
                    end
                    OP_TXS: begin
                        ctrl[SB_FROM_X] = 1'b1;
                        ctrl[LOAD_SP] = 1'b1;
                    end
                    OP_TYA: begin
                        ctrl[SB_FROM_Y] = 1'b1;
                        ctrl[LOAD_ACC] = 1'b1;
                    end
                    OP_SEC, OP_CLC: begin
                        ctrl[PSR_DATA] = (cur_opcode == OP_SEC);
                        ctrl[LOAD_C] = 1'b1;
                    end
                    OP_SED, OP_CLD: begin
                        ctrl[PSR_DATA] = (cur_opcode == OP_SED);
                        ctrl[LOAD_D] = 1'b1;
                    end
                    OP_SEI, OP_CLI: begin
                        ctrl[PSR_DATA] = (cur_opcode == OP_SEI);
                        ctrl[LOAD_I] = 1'b1;
                    end
                    OP_CLV: ctrl[LOAD_V] = 1'b1;
                    // NOP and unknown opcodes only step the PC
                    OP_NOP:  ctrl = '0;
                    default: ctrl = '0;
                endcase
            end
            SEQ_T1: begin
                ctrl[PC_INC] = 1'b1;
                ctrl[LOAD_AB] = 1'b1;
                // Write back the held ALU result
                case (cur_opcode)
                    OP_ASL_A, OP_ROL_A, OP_LSR_A, OP_ROR_A: begin
                        ctrl[SB_FROM_ALU] = 1'b1;
                        ctrl[LOAD_ACC] = 1'b1;
                        ctrl[CARRY_FROM_ALU] = 1'b1;
                    end
                    OP_DEX, OP_INX: begin
                        ctrl[SB_FROM_ALU] = 1'b1;
                        ctrl[LOAD_X] = 1'b1;
                    end
                    OP_DEY, OP_INY: begin
                        ctrl[SB_FROM_ALU] = 1'b1;
                        ctrl[LOAD_Y] = 1'b1;
                    end
                    default: ctrl[SB_FROM_ALU] = 1'b0;
                endcase
            end
            default: ctrl = '0;
        endcase
    end

    // The register file ORs the stack bus sources together
    always_comb begin
        a_single_sb_source: assert ($onehot0({ctrl[SB_FROM_ACC], ctrl[SB_FROM_X],
            ctrl[SB_FROM_Y], ctrl[SB_FROM_SP], ctrl[SB_FROM_ALU]}))
            else $error("more than one stack bus source selected");
    end

endmodule

`default_nettype wire

// ==== dv/tb_vectors.svh ====
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// Columns: test name, opcode, expected acc, x, y, sp, psr
// Each row starts from the registers that the row before it left behind
task automatic load_vectors();
    // Index registers wrap around from the reset values
    add_vector("dex_wrap",   OP_DEX,   8'h00, 8'hFF, 8'h00, 8'hFF, 8'h00);
    add_vector("inx_wrap",   OP_INX,   8'h00, 8'h00, 8'h00, 8'hFF, 8'h00);
    add_vector("dey_wrap",   OP_DEY,   8'h00, 8'h00, 8'hFF, 8'hFF, 8'h00);
    add_vector("iny_wrap",   OP_INY,   8'h00, 8'h00, 8'h00, 8'hFF, 8'h00);
    // Transfers between registers
    add_vector("tsx",        OP_TSX,   8'h00, 8'hFF, 8'h00, 8'hFF, 8'h00);
    add_vector("dex",        OP_DEX,   8'h00, 8'hFE, 8'h00, 8'hFF, 8'h00);
    add_vector("txs",        OP_TXS,   8'h00, 8'hFE, 8'h00, 8'hFE, 8'h00);
    add_vector("txa",        OP_TXA,   8'hFE, 8'hFE, 8'h00, 8'hFE, 8'h00);
    add_vector("tay",        OP_TAY,   8'hFE, 8'hFE, 8'hFE, 8'hFE, 8'h00);
    add_vector("inx",        OP_INX,   8'hFE, 8'hFF, 8'hFE, 8'hFE, 8'h00);
    add_vector("txa_ff",     OP_TXA,   8'hFF, 8'hFF, 8'hFE, 8'hFE, 8'h00);
    // Shifts and rotates through C, starting from A = FF
    add_vector("asl",        OP_ASL_A, 8'hFE, 8'hFF, 8'hFE, 8'hFE, 8'h01);
    add_vector("rol",        OP_ROL_A, 8'hFD, 8'hFF, 8'hFE, 8'hFE, 8'h01);
    add_vector("lsr",        OP_LSR_A, 8'h7E, 8'hFF, 8'hFE, 8'hFE, 8'h01);
    add_vector("ror",        OP_ROR_A, 8'hBF, 8'hFF, 8'hFE, 8'hFE, 8'h00);
    add_vector("tya",        OP_TYA,   8'hFE, 8'hFF, 8'hFE, 8'hFE, 8'h00);
    add_vector("tax",        OP_TAX,   8'hFE, 8'hFE, 8'hFE, 8'hFE, 8'h00);
    // C stays set across DEY and INY
    add_vector("sec",        OP_SEC,   8'hFE, 8'hFE, 8'hFE, 8'hFE, 8'h01);
    add_vector("dey_keep_c", OP_DEY,   8'hFE, 8'hFE, 8'hFD, 8'hFE, 8'h01);
    add_vector("iny_keep_c", OP_INY,   8'hFE, 8'hFE, 8'hFE, 8'hFE, 8'h01);
    // Flag set and clear
    add_vector("sed",        OP_SED,   8'hFE, 8'hFE, 8'hFE, 8'hFE, 8'h09);
    add_vector("sei",        OP_SEI,   8'hFE, 8'hFE, 8'hFE, 8'hFE, 8'h0D);
    add_vector("clc",        OP_CLC,   8'hFE, 8'hFE, 8'hFE, 8'hFE, 8'h0C);
    add_vector("cld",        OP_CLD,   8'hFE, 8'hFE, 8'hFE, 8'hFE, 8'h04);
    add_vector("cli",        OP_CLI,   8'hFE, 8'hFE, 8'hFE, 8'hFE, 8'h00);
    add_vector("sec_again",  OP_SEC,   8'hFE, 8'hFE, 8'hFE, 8'hFE, 8'h01);
    // No register change, only the address moves
    add_vector("nop",        OP_NOP,   8'hFE, 8'hFE, 8'hFE, 8'hFE, 8'h01);
    add_vector("unknown_ff", 8'hFF,    8'hFE, 8'hFE, 8'hFE, 8'hFE, 8'h01);
    add_vector("clv",        OP_CLV,   8'hFE, 8'hFE, 8'hFE, 8'hFE, 8'h01);
endtask

`endif

// ==== dv/tb_cpu.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_cpu import cpu_pkg::*; ();

    localparam int NUM_VECTORS = 29;
    // Four cycles per row plus reset and the reset check
    localparam int TIMEOUT_CYCLES = 4 * NUM_VECTORS + 20;

    logic  clk;
    logic  reset;
    logic  instr_strobe;
    byte_t opcode;
    logic  busy;
    addr_t address;
    byte_t acc;
    byte_t x;
    byte_t y;
    byte_t sp;
    byte_t psr;

    string vec_name [NUM_VECTORS];
    byte_t vec_opcode [NUM_VECTORS];
    byte_t exp_acc [NUM_VECTORS];
    byte_t exp_x [NUM_VECTORS];
    byte_t exp_y [NUM_VECTORS];
    byte_t exp_sp [NUM_VECTORS];
    byte_t exp_psr [NUM_VECTORS];

    int    vec_count;
    int    error_count;
    int    check_count;
    int    cycle_count;
    int    idx;
    addr_t expected_address;

    cpu_top DUT (
        .clk          (clk),
        .reset        (reset),
        .instr_strobe (instr_strobe),
        .opcode       (opcode),
        .busy         (busy),
        .address      (address),
        .acc          (acc),
        .x            (x),
        .y            (y),
        .sp           (sp),
        .psr          (psr)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic add_vector(input string name, input byte_t op, input byte_t acc_exp,
            input byte_t x_exp, input byte_t y_exp, input byte_t sp_exp,
            input byte_t psr_exp);
        if (vec_count >= NUM_VECTORS) begin
            $display("error: vector table has more than %0d rows", NUM_VECTORS);
            error_count++;
        end else begin
            vec_name[vec_count] = name;
            vec_opcode[vec_count] = op;
            exp_acc[vec_count] = acc_exp;
            exp_x[vec_count] = x_exp;
            exp_y[vec_count] = y_exp;
            exp_sp[vec_count] = sp_exp;
            exp_psr[vec_count] = psr_exp;
            vec_count++;
        end
    endtask

    `include "tb_vectors.svh"

    task automatic check_value(input string test_name, input string field,
            input logic [15:0] expected, input logic [15:0] actual);
        check_count++;
        if (actual !== expected) begin
            $display("mismatch %s %s: expected %h, actual %h",
                test_name, field, expected, actual);
            error_count++;
        end
    endtask

    task automatic check_registers(input string test_name, input byte_t acc_exp,
            input byte_t x_exp, input byte_t y_exp, input byte_t sp_exp,
            input byte_t psr_exp, input addr_t addr_exp);
        check_value(test_name, "busy", 16'd0, 16'(busy));
        check_value(test_name, "address", addr_exp, address);
        check_value(test_name, "acc", 16'(acc_exp), 16'(acc));
        check_value(test_name, "x", 16'(x_exp), 16'(x));
        check_value(test_name, "y", 16'(y_exp), 16'(y));
        check_value(test_name, "sp", 16'(sp_exp), 16'(sp));
        check_value(test_name, "psr", 16'(psr_exp), 16'(psr));
    endtask

    // Strobe at edge k, T0 and T1 follow, results settle after edge k+2
    task automatic run_vector(input int row);
        while (busy) begin
            @(negedge clk);
        end
        @(posedge clk);
        instr_strobe <= 1'b1;
        opcode <= vec_opcode[row];
        @(posedge clk);
        instr_strobe <= 1'b0;
        @(negedge clk);
        check_value(vec_name[row], "busy in T0", 16'd1, 16'(busy));
        @(negedge clk);
        check_value(vec_name[row], "busy in T1", 16'd1, 16'(busy));
        @(negedge clk);
        check_registers(vec_name[row], exp_acc[row], exp_x[row], exp_y[row],
            exp_sp[row], exp_psr[row], expected_address);
    endtask

    initial begin
        reset = 1'b1;
        instr_strobe = 1'b0;
        opcode = 8'h00;
        vec_count = 0;
        error_count = 0;
        check_count = 0;
        load_vectors();
        if (vec_count != NUM_VECTORS) begin
            $display("error: vector table holds %0d rows instead of %0d",
                vec_count, NUM_VECTORS);
            error_count++;
        end

        repeat (3) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_registers("reset_state", 8'h00, 8'h00, 8'h00, RESET_SP, 8'h00, RESET_PC);

        // Every instruction moves the address by one
        expected_address = RESET_PC;
        for (idx = 0; idx < vec_count; idx++) begin
            expected_address = expected_address + 16'd1;
            run_vector(idx);
        end

        $display("rows: %0d checks: %0d errors: %0d", vec_count, check_count, error_count);
        if (error_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("error: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire

// ==== rtl/cpu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_top import cpu_pkg::*; (
    input  wire logic   clk,
    input  wire logic   reset,
    input  wire logic   instr_strobe,
    input  wire byte_t  opcode,
    output logic        busy,
    output addr_t       address,
    output byte_t       acc,
    output byte_t       x,
    output byte_t       y,
    output byte_t       sp,
    output byte_t       psr
);

    byte_t      cur_opcode;
    seq_state_e t_state;
    ctrl_word_t ctrl;
    byte_t      alu_a;
    byte_t      alu_b;
    logic       alu_carry_in;
    byte_t      alu_result;
    logic       alu_carry_out;

    // Input side
    instr_sequencer u_sequencer (
        .clk          (clk),
        .reset        (reset),
        .instr_strobe (instr_strobe),
        .opcode       (opcode),
        .busy         (busy),
        .cur_opcode   (cur_opcode),
        .t_state      (t_state)
    );

    // Processing
    implied_decoder u_decoder (
        .cur_opcode (cur_opcode),
        .t_state    (t_state),
        .ctrl       (ctrl)
    );

    bus_alu u_alu (
        .clk           (clk),
        .reset         (reset),
        .ctrl          (ctrl),
        .alu_a         (alu_a),
        .alu_b         (alu_b),
        .alu_carry_in  (alu_carry_in),
        .alu_result    (alu_result),
        .alu_carry_out (alu_carry_out)
    );

    // Output side
    register_file u_regs (
        .clk           (clk),
        .reset         (reset),
        .ctrl          (ctrl),
        .alu_result    (alu_result),
        .alu_carry_out (alu_carry_out),
        .alu_a         (alu_a),
        .alu_b         (alu_b),
        .alu_carry_in  (alu_carry_in),
        .acc           (acc),
        .x             (x),
        .y             (y),
        .sp            (sp),
        .psr           (psr)
    );

    address_unit u_addr (
        .clk     (clk),
        .reset   (reset),
        .ctrl    (ctrl),
        .address (address)
    );

endmodule

`default_nettype wire

// ==== rtl/instr_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module instr_sequencer import cpu_pkg::*; (
    input  wire logic   clk,
    input  wire logic   reset,
    input  wire logic   instr_strobe,
    input  wire byte_t  opcode,
    output logic        busy,
    output byte_t       cur_opcode,
    output seq_state_e  t_state
);

    logic accept;

    assign accept = (t_state == SEQ_IDLE) && instr_strobe;
    assign busy = (t_state != SEQ_IDLE);

    always_ff @(posedge clk) begin
        if (reset) begin
            t_state <= SEQ_IDLE;
        end else begin
            case (t_state)
                SEQ_IDLE: t_state <= accept ? SEQ_T0 : SEQ_IDLE;
                SEQ_T0:   t_state <= SEQ_T1;
                default:  t_state <= SEQ_IDLE;
            endcase
        end
    end

    // Opcode is held for the whole instruction
    always_ff @(posedge clk) begin
        if (accept) begin
            cur_opcode <= opcode;
        end
    end

    // A strobe during T0 or T1 would be dropped
    a_no_strobe_when_busy: assert property (@(posedge clk) disable iff (reset)
        busy |-> !instr_strobe)
        else $error("instr_strobe raised while busy");

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build the tb_cpu simulation with Verilator, run it, and scan the log
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f src.f --top-module tb_cpu -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/Vtb_cpu > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "FAIL: see errors above" "$LOG"; then
    exit 1
fi
exit 0

// ==== src.f ====
+incdir+dv
common/cpu_pkg.sv
rtl/instr_sequencer.sv
decode/implied_decoder.sv
datapath/register_file.sv
datapath/bus_alu.sv
datapath/address_unit.sv
rtl/cpu_top.sv
dv/tb_cpu.sv
